// File: src/soc_pkg.sv
package soc_pkg;

    // Bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // Boot ROM, read-only from the bus
    localparam logic [addr_w-1:0] rom_base = 32'h0000_0000;
    localparam logic [addr_w-1:0] rom_size = 32'h0000_1000;

    // Data RAM sits right above the ROM
    localparam logic [addr_w-1:0] ram_base = 32'h0000_1000;
    localparam logic [addr_w-1:0] ram_size = 32'h0000_1000;

    // Memory-mapped IO registers
    // Key register holds ASCII in 7:0 and the scan code in 15:8
    localparam logic [addr_w-1:0] key_addr = 32'h0000_2000;
    // Low byte of a write goes to the UART
    localparam logic [addr_w-1:0] uart_data_addr = 32'h0000_2004;
    // Read gives the free UART credit count
    localparam logic [addr_w-1:0] uart_stat_addr = 32'h0000_2008;

    // Access size codes on bus_bytes
    localparam logic [1:0] size_word = 2'd0;
    localparam logic [1:0] size_byte = 2'd1;
    localparam logic [1:0] size_half = 2'd2;

    // One block memory spans ROM and RAM, 32-bit words
    localparam int mem_words = 2048;

endpackage

// File: src/ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] scan_code,
    output logic [7:0] ascii_code,
    output logic       key_pressed,
    output logic       key_released
);

    // Set 2 scan code to lower-case ASCII, zero when unmapped
    function automatic logic [7:0] keymap(input logic [7:0] code);
        case (code)
            8'h1C: keymap = 8'h61;
            8'h32: keymap = 8'h62;
            8'h21: keymap = 8'h63;
            8'h23: keymap = 8'h64;
            8'h24: keymap = 8'h65;
            8'h2B: keymap = 8'h66;
            8'h34: keymap = 8'h67;
            8'h33: keymap = 8'h68;
            8'h43: keymap = 8'h69;
            8'h3B: keymap = 8'h6A;
            8'h42: keymap = 8'h6B;
            8'h4B: keymap = 8'h6C;
            8'h3A: keymap = 8'h6D;
            8'h31: keymap = 8'h6E;
            8'h44: keymap = 8'h6F;
            8'h4D: keymap = 8'h70;
            8'h15: keymap = 8'h71;
            8'h2D: keymap = 8'h72;
            8'h1B: keymap = 8'h73;
            8'h2C: keymap = 8'h74;
            8'h3C: keymap = 8'h75;
            8'h2A: keymap = 8'h76;
            8'h1D: keymap = 8'h77;
            8'h22: keymap = 8'h78;
            8'h35: keymap = 8'h79;
            8'h1A: keymap = 8'h7A;
            // Digits on the main row
            8'h45: keymap = 8'h30;
            8'h16: keymap = 8'h31;
            8'h1E: keymap = 8'h32;
            8'h26: keymap = 8'h33;
            8'h25: keymap = 8'h34;
            8'h2E: keymap = 8'h35;
            8'h36: keymap = 8'h36;
            8'h3D: keymap = 8'h37;
            8'h3E: keymap = 8'h38;
            8'h46: keymap = 8'h39;
            default: keymap = 8'h00;
        endcase
    endfunction

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic [3:0] bit_cnt;
    logic [8:0] shreg;
    logic       release_armed;
    logic       clk_fall;

    // Two-flop synchronisers, lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Device changes data on rising edge, so sample on falling
    assign clk_fall = clk_prev & ~clk_sync[1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt       <= 4'd0;
            shreg         <= 9'd0;
            release_armed <= 1'b0;
            scan_code     <= 8'd0;
            ascii_code    <= 8'd0;
            key_pressed   <= 1'b0;
            key_released  <= 1'b0;
        end else begin
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd0) begin
                    // Wait here until a start bit of 0 shows up
                    if (!dat_sync[1])
                        bit_cnt <= 4'd1;
                end else if (bit_cnt != 4'd10) begin
                    // Data LSB first, then parity lands in bit 8
                    shreg   <= {dat_sync[1], shreg[8:1]};
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    bit_cnt <= 4'd0;
                    // Stop must be 1 and data plus parity must be odd
                    if (dat_sync[1] && ^shreg) begin
                        if (shreg[7:0] == 8'hF0) begin
                            release_armed <= 1'b1;
                        end else begin
                            scan_code     <= shreg[7:0];
                            ascii_code    <= keymap(shreg[7:0]);
                            key_pressed   <= !release_armed;
                            key_released  <= release_armed;
                            release_armed <= 1'b0;
                        end
                    end
                end
            end
        end
    end

endmodule

// File: src/key_irq_ctrl.sv
`timescale 1ns/1ps

module key_irq_ctrl
    import soc_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [7:0]        scan_code,
    input  logic [7:0]        ascii_code,
    input  logic              key_pressed,
    input  logic              key_released,
    input  logic              irq_ack,
    output logic [data_w-1:0] key_word,
    output logic [3:0]        irq_vector
);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_word   <= '0;
            irq_vector <= 4'd0;
        end else begin
            // Every press updates the visible key even when unmapped
            if (key_pressed)
                key_word <= {{(data_w-16){1'b0}}, scan_code, ascii_code};

            // One-shot vector ignores presses while pending
            if (irq_vector != 4'd0) begin
                if (irq_ack)
                    irq_vector <= 4'd0;
            end else if (key_pressed && ascii_code != 8'd0) begin
                irq_vector <= 4'd1;
            end
        end
    end

    // Pending interrupt is only dropped by the CPU acknowledge
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (irq_vector != 4'd0 && !irq_ack) |=> irq_vector != 4'd0);

endmodule

// File: src/bus_controller.sv
`timescale 1ns/1ps

module bus_controller
    import soc_pkg::*;
#(
    parameter int uart_depth = 4
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [addr_w-1:0] bus_address,
    input  logic [1:0]        bus_bytes,
    input  logic [data_w-1:0] bus_write_data,
    input  logic              bus_write_enable,
    input  logic              bus_read_enable,
    output logic [data_w-1:0] bus_read_data,
    input  logic [data_w-1:0] key_word,
    output logic              tx_push,
    output logic [7:0]        tx_byte,
    input  logic              tx_credit
);

    localparam int mem_aw = $clog2(mem_words);
    localparam int cw     = $clog2(uart_depth + 1);

    logic [data_w-1:0] mem [0:mem_words-1];

    logic              rom_sel;
    logic              ram_sel;
    logic              key_sel;
    logic              data_sel;
    logic              stat_sel;
    logic [mem_aw-1:0] mem_idx;
    logic [3:0]        wr_be;
    logic [data_w-1:0] wr_data;
    logic [data_w-1:0] mem_rd;
    logic [data_w-1:0] io_rd;
    logic              rd_from_mem;
    logic [cw-1:0]     credits;
    logic              push_ok;

    // Regions are aligned powers of two, mask off the offset
    assign rom_sel  = (bus_address & ~(rom_size - 1'b1)) == rom_base;
    assign ram_sel  = (bus_address & ~(ram_size - 1'b1)) == ram_base;
    assign key_sel  = bus_address == key_addr;
    assign data_sel = bus_address == uart_data_addr;
    assign stat_sel = bus_address == uart_stat_addr;

    // ROM and RAM share one array, word index from the low bits
    assign mem_idx = bus_address[mem_aw+1:2];

    // Lane enables and replicated data, offset comes from address 1:0
    always_comb begin
        case (bus_bytes)
            size_word: begin
                wr_be   = 4'b1111;
                wr_data = bus_write_data;
            end
            size_byte: begin
                wr_be   = 4'b0001 << bus_address[1:0];
                wr_data = {4{bus_write_data[7:0]}};
            end
            size_half: begin
                // Half lanes sit at offset 0 or 2
                wr_be   = bus_address[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{bus_write_data[15:0]}};
            end
            default: begin
                wr_be   = 4'b0000;
                wr_data = bus_write_data;
            end
        endcase
    end

    // ROM image is all zeros
    initial begin
        for (int i = 0; i < mem_words; i++)
            mem[i] = '0;
    end

    // Block memory port, only RAM accepts writes
    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable && ram_sel) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b])
                    mem[mem_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
        if (bus_read_enable)
            mem_rd <= mem[mem_idx];
    end

    // IO side of the read path, held until the next read
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_from_mem <= 1'b0;
            io_rd       <= '0;
        end else if (bus_read_enable) begin
            rd_from_mem <= rom_sel || ram_sel;
            if (key_sel)
                io_rd <= key_word;
            else if (stat_sel)
                io_rd <= {{(data_w-cw){1'b0}}, credits};
            else
                io_rd <= '0;
        end
    end

    assign bus_read_data = rd_from_mem ? mem_rd : io_rd;

    // Data write only goes through with a credit in hand
    assign push_ok = bus_write_enable && data_sel && credits != '0;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tx_push <= 1'b0;
            credits <= cw'(uart_depth);
        end else begin
            tx_push <= push_ok;
            case ({push_ok, tx_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Byte travels alongside the registered push
    always_ff @(posedge CLOCK_50) begin
        if (push_ok)
            tx_byte <= bus_write_data[7:0];
    end

    // CPU side never reads and writes at once
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

    // Transmitter hands back no more credits than it took
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        credits <= cw'(uart_depth));

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int uart_depth = 4,
    parameter int baud_div   = 434
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       tx_push,
    input  logic [7:0] tx_byte,
    output logic       tx_credit,
    output logic       uart_txd
);

    localparam int aw = (uart_depth > 1) ? $clog2(uart_depth) : 1;
    localparam int cw = $clog2(uart_depth + 1);
    localparam int bw = (baud_div > 1) ? $clog2(baud_div) : 1;

    logic [7:0]    fifo [0:uart_depth-1];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic          fifo_full;
    logic          pop;

    logic          busy;
    logic [bw-1:0] baud_cnt;
    logic [3:0]    bit_idx;
    logic [9:0]    shifter;

    assign fifo_full = count == cw'(uart_depth);
    // Load the serialiser as soon as it is idle and a byte waits
    assign pop = !busy && count != '0;

    always_ff @(posedge CLOCK_50) begin
        if (tx_push && !fifo_full)
            fifo[wr_ptr] <= tx_byte;
    end

    // Pointers wrap by hand so any depth works
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (tx_push && !fifo_full)
                wr_ptr <= (wr_ptr == aw'(uart_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == aw'(uart_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({tx_push && !fifo_full, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Shifter fills with ones so the line rests high between frames
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy      <= 1'b0;
            baud_cnt  <= '0;
            bit_idx   <= 4'd0;
            shifter   <= 10'h3FF;
            tx_credit <= 1'b0;
        end else begin
            tx_credit <= 1'b0;
            if (pop) begin
                // Stop, data LSB first, start in bit 0
                shifter  <= {1'b1, fifo[rd_ptr], 1'b0};
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= 4'd0;
            end else if (busy) begin
                if (baud_cnt == bw'(baud_div - 1)) begin
                    baud_cnt <= '0;
                    shifter  <= {1'b1, shifter[9:1]};
                    if (bit_idx == 4'd9) begin
                        // End of stop bit frees one FIFO slot upstream
                        busy      <= 1'b0;
                        tx_credit <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 4'd1;
                    end
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
        end
    end

    assign uart_txd = shifter[0];

    // Credit counter upstream must keep pushes within the FIFO
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        tx_push |-> !fifo_full);

endmodule

// File: src/board_top.sv
`timescale 1ns/1ps

module board_top
    import soc_pkg::*;
#(
    parameter int uart_depth = 4,
    parameter int baud_div   = 434
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              PS2_CLK,
    input  logic              PS2_DAT,
    input  logic [addr_w-1:0] bus_address,
    input  logic [1:0]        bus_bytes,
    input  logic [data_w-1:0] bus_write_data,
    input  logic              bus_write_enable,
    input  logic              bus_read_enable,
    output logic [data_w-1:0] bus_read_data,
    input  logic              irq_ack,
    output logic [3:0]        irq_vector,
    output logic              uart_txd
);

    // Keyboard to key register
    logic [7:0]        scan_code;
    logic [7:0]        ascii_code;
    logic              key_pressed;
    logic              key_released;
    logic [data_w-1:0] key_word;

    // Controller to transmitter, credits flow back
    logic              tx_push;
    logic [7:0]        tx_byte;
    logic              tx_credit;

    ps2_receiver u_ps2 (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .ps2_clk      (PS2_CLK),
        .ps2_dat      (PS2_DAT),
        .scan_code    (scan_code),
        .ascii_code   (ascii_code),
        .key_pressed  (key_pressed),
        .key_released (key_released)
    );

    key_irq_ctrl u_key (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .scan_code    (scan_code),
        .ascii_code   (ascii_code),
        .key_pressed  (key_pressed),
        .key_released (key_released),
        .irq_ack      (irq_ack),
        .key_word     (key_word),
        .irq_vector   (irq_vector)
    );

    bus_controller #(
        .uart_depth (uart_depth)
    ) u_bus (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_bytes        (bus_bytes),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_word         (key_word),
        .tx_push          (tx_push),
        .tx_byte          (tx_byte),
        .tx_credit        (tx_credit)
    );

    uart_tx #(
        .uart_depth (uart_depth),
        .baud_div   (baud_div)
    ) u_uart (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .tx_push   (tx_push),
        .tx_byte   (tx_byte),
        .tx_credit (tx_credit),
        .uart_txd  (uart_txd)
    );

endmodule

// File: verif/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 10
) (
    output logic CLOCK_50,
    output logic KEY0
);

    // Free-running system clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #(period_ns / 2) CLOCK_50 = ~CLOCK_50;
    end

    // Reset held low, released on a rising edge
    initial begin
        KEY0 = 1'b0;
        repeat (reset_cycles) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

// File: verif/tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top
    import soc_pkg::*;
;

    localparam int baud_div   = 8;
    localparam int uart_depth = 4;
    localparam int max_ops    = 64;

    logic        CLOCK_50;
    logic        KEY0;
    logic        ps2_clk_pin;
    logic        ps2_dat_pin;
    logic [31:0] bus_address;
    logic [1:0]  bus_bytes;
    logic [31:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [31:0] bus_read_data;
    logic        irq_ack;
    logic [3:0]  irq_vector;
    logic        uart_txd;

    // Five pattern words per operation
    logic [31:0] pat [0:5*max_ops-1];
    // Reference RAM keyed by word index
    logic [31:0] model_mem [logic [29:0]];
    // Bytes seen on the serial line in arrival order
    logic [7:0]  rx_q [$];
    int          mismatch_count = 0;
    int          other_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    clock_gen #(
        .period_ns    (100),
        .reset_cycles (10)
    ) u_clk (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    board_top #(
        .uart_depth (uart_depth),
        .baud_div   (baud_div)
    ) dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .PS2_CLK          (ps2_clk_pin),
        .PS2_DAT          (ps2_dat_pin),
        .bus_address      (bus_address),
        .bus_bytes        (bus_bytes),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .irq_ack          (irq_ack),
        .irq_vector       (irq_vector),
        .uart_txd         (uart_txd)
    );

    // Little-endian merge with bytes at offset*8 and halves at 0 or 16
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] addr,
                                                input logic [1:0] size, input logic [31:0] data);
        logic [31:0] word;
        word = old;
        case (size)
            size_word: word = data;
            size_byte: word[{addr[1:0], 3'b000} +: 8] = data[7:0];
            size_half: word[{addr[1], 4'b0000} +: 16] = data[15:0];
            default:   word = old;
        endcase
        return word;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return model_mem.exists(addr[31:2]) ? model_mem[addr[31:2]] : 32'd0;
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [1:0] size,
                             input logic [31:0] data);
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_bytes        <= size;
        bus_write_data   <= data;
        bus_write_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
        // ROM and IO writes leave memory alone
        if (addr >= ram_base && addr < ram_base + ram_size)
            model_mem[addr[31:2]] = merge_lanes(model_word(addr), addr, size, data);
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge CLOCK_50);
        bus_address     <= addr;
        bus_read_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        // Data arrives one cycle later and then holds
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        if (bus_read_data !== exp) begin
            mismatch_count++;
            $display("mismatch bus_read_data at %h: got %h expected %h", addr, bus_read_data, exp);
        end
        if (addr < ram_base + ram_size && bus_read_data !== model_word(addr)) begin
            mismatch_count++;
            $display("mismatch bus_read_data at %h: got %h model %h", addr, bus_read_data,
                     model_word(addr));
        end
    endtask

    // Frame is start, data LSB first, odd parity and stop
    // Each clock half-period lasts 10 cycles
    task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int b = 0; b < 11; b++) begin
            @(posedge CLOCK_50);
            ps2_dat_pin <= frame[b];
            repeat (10) @(posedge CLOCK_50);
            ps2_clk_pin <= 1'b0;
            repeat (10) @(posedge CLOCK_50);
            ps2_clk_pin <= 1'b1;
        end
    endtask

    // Serial monitor samples mid-bit on the falling clock
    initial begin : uart_monitor
        logic [7:0] rx;
        wait (KEY0);
        forever begin
            @(negedge CLOCK_50);
            if (uart_txd == 1'b0) begin
                repeat (baud_div / 2) @(negedge CLOCK_50);
                if (uart_txd !== 1'b0) begin
                    other_count++;
                    $display("uart start bit did not stay low");
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (baud_div) @(negedge CLOCK_50);
                    rx[b] = uart_txd;
                end
                repeat (baud_div) @(negedge CLOCK_50);
                if (uart_txd !== 1'b1) begin
                    other_count++;
                    $display("uart stop bit was low for byte %h", rx);
                end
                rx_q.push_back(rx);
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge CLOCK_50);
            cycle_count++;
        end
        $display("timeout: run did not finish in %0d cycles, %0d mismatches, %0d other failures",
                 cycle_limit, mismatch_count, other_count);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        int          n_ops;
        int          gap;
        logic [31:0] op;
        logic [31:0] arg;
        logic [31:0] size;
        logic [31:0] data;
        logic [31:0] exp;
        logic [7:0]  got;
        bus_address      = 32'd0;
        bus_bytes        = 2'd0;
        bus_write_data   = 32'd0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        irq_ack          = 1'b0;
        ps2_clk_pin      = 1'b1;
        ps2_dat_pin      = 1'b1;
        void'($urandom(32'h32992cf3));
        for (int i = 0; i < 5 * max_ops; i++)
            pat[i] = 32'd0;
        $readmemh("verif/board_patterns.hex", pat);
        // Opcode zero ends the table
        n_ops = 0;
        while (n_ops < max_ops && pat[5*n_ops] != 32'd0)
            n_ops++;
        if (n_ops == 0) begin
            other_count++;
            $display("no operations loaded from the pattern file");
        end
        cycle_limit = n_ops * 600;
        wait (KEY0);
        @(negedge CLOCK_50);
        if (irq_vector !== 4'd0) begin
            mismatch_count++;
            $display("mismatch irq_vector after reset: got %h expected %h", irq_vector, 4'd0);
        end
        if (uart_txd !== 1'b1) begin
            mismatch_count++;
            $display("mismatch uart_txd after reset: got %h expected %h", uart_txd, 1'b1);
        end
        if (bus_read_data !== 32'd0) begin
            mismatch_count++;
            $display("mismatch bus_read_data after reset: got %h expected %h",
                     bus_read_data, 32'd0);
        end
        for (int i = 0; i < n_ops; i++) begin
            op   = pat[5*i];
            arg  = pat[5*i+1];
            size = pat[5*i+2];
            data = pat[5*i+3];
            exp  = pat[5*i+4];
            case (op)
                32'd1: bus_write(arg, size[1:0], data);
                32'd2: bus_read(arg, exp);
                32'd3, 32'd4: begin
                    if (op == 32'd3) begin
                        send_ps2(arg[7:0], size[0]);
                        repeat (10) @(posedge CLOCK_50);
                    end else begin
                        @(posedge CLOCK_50);
                        irq_ack <= 1'b1;
                        @(posedge CLOCK_50);
                        irq_ack <= 1'b0;
                        @(posedge CLOCK_50);
                    end
                    @(negedge CLOCK_50);
                    if (irq_vector !== exp[3:0]) begin
                        mismatch_count++;
                        $display("mismatch irq_vector: got %h expected %h", irq_vector, exp[3:0]);
                    end
                end
                32'd5: begin
                    // Wait for the monitor to deliver the next byte
                    while (rx_q.size() == 0)
                        @(posedge CLOCK_50);
                    got = rx_q.pop_front();
                    if (got !== exp[7:0]) begin
                        mismatch_count++;
                        $display("mismatch uart_txd byte: got %h expected %h", got, exp[7:0]);
                    end
                end
                32'd6: begin
                    repeat (data) @(posedge CLOCK_50);
                    if (rx_q.size() != exp) begin
                        mismatch_count++;
                        $display("mismatch uart_txd byte count: got %h expected %h",
                                 rx_q.size(), exp);
                    end
                end
                default: begin
                    other_count++;
                    $display("unknown opcode %h on pattern %0d", op, i);
                end
            endcase
            // Short idle gap between operations
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge CLOCK_50);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: soc_bus.f
src/soc_pkg.sv
src/ps2_receiver.sv
src/key_irq_ctrl.sv
src/bus_controller.sv
src/uart_tx.sv
src/board_top.sv
verif/clock_gen.sv
verif/tb_board_top.sv

// File: Makefile
# Verilator flow for the board bus subsystem, run from the project root

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_board_top -f soc_bus.f

# Status comes from the pass line in the simulator output
run: compile
	@out=$$(./obj_dir/Vtb_board_top); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// File: verif/board_patterns.hex
// Columns: opcode, address or scan code, size or flag, data, expected
// Opcodes: 1 write, 2 read, 3 PS/2 key (flag 1 = bad parity), 4 irq ack, 5 uart byte, 6 quiet wait
// RAM word, byte and half lanes
1 00001000 0 11223344 00000000
2 00001000 0 00000000 11223344
1 00001001 1 FFFFFFAA 00000000
2 00001000 0 00000000 1122AA44
1 00001002 2 0000BEEF 00000000
2 00001000 0 00000000 BEEFAA44
1 00001003 1 0000005A 00000000
2 00001000 0 00000000 5AEFAA44
1 00001006 2 00001234 00000000
2 00001004 0 00000000 12340000
1 00001FFC 0 CAFEF00D 00000000
2 00001FFC 0 00000000 CAFEF00D
// ROM ignores writes, unmapped reads give zero
1 00000010 0 FFFFFFFF 00000000
2 00000010 0 00000000 00000000
2 00003000 0 00000000 00000000
// Key press, ack, break sequence, bad parity
3 0000001C 0 00000000 00000001
2 00002000 0 00000000 00001C61
4 00000000 0 00000000 00000000
3 000000F0 0 00000000 00000000
3 0000001C 0 00000000 00000000
3 00000032 1 00000000 00000000
2 00002000 0 00000000 00001C61
3 00000016 0 00000000 00000001
2 00002000 0 00000000 00001631
4 00000000 0 00000000 00000000
// UART credits, fifth write is dropped
2 00002008 0 00000000 00000004
1 00002004 0 00000041 00000000
1 00002004 0 00000042 00000000
1 00002004 0 00000043 00000000
1 00002004 0 00000044 00000000
2 00002008 0 00000000 00000000
1 00002004 0 00000045 00000000
5 00000000 0 00000000 00000041
5 00000000 0 00000000 00000042
5 00000000 0 00000000 00000043
5 00000000 0 00000000 00000044
6 00000000 0 0000012C 00000000
2 00002008 0 00000000 00000004
